//--- source/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath and address width
`define RV_XLEN 32

// register file address width
`define RV_RADDR_W 5

// value loaded into pipeline registers on reset and flush
`define RV_PIPE_RST '0

`endif

//--- source/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10 // lui and csr reads
	} alu_op_e;

	typedef enum logic [1:0] {
		wb_alu = 2'd0,
		wb_mem = 2'd1,
		wb_pc4 = 2'd2,
		wb_csr = 2'd3
	} wb_sel_e;

	typedef enum logic [1:0] {
		fwd_reg = 2'd0,
		fwd_mem = 2'd1, // EX/MEM alu result
		fwd_wb  = 2'd2  // writeback data
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e                alu_op;
		logic                   a_pc;    // operand a from pc
		logic                   b_imm;   // operand b from immediate
		logic                   csr_b;   // csr value replaces operand b
		logic                   br_un;
		logic                   mem_we;
		logic                   mem_req;
		wb_sel_e                wb_sel;
		logic                   reg_we;
		logic [`RV_RADDR_W-1:0] rd;
	} ex_ctrl_t;

endpackage

//--- source/ex_mem_if.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

interface ex_mem_if;

	logic [`RV_XLEN-1:0]    alu;
	logic [`RV_XLEN-1:0]    rs2;       // forwarded store data
	logic [`RV_XLEN-1:0]    pc4;
	logic [`RV_XLEN-1:0]    csr_rdata;
	logic                   mem_we;
	logic                   mem_req;
	rv_pkg::wb_sel_e        wb_sel;
	logic                   reg_we;
	logic [`RV_RADDR_W-1:0] rd;

	modport stage (
		output alu, rs2, pc4, csr_rdata,
		output mem_we, mem_req,
		output wb_sel, reg_we, rd
	);

	// wb stage and forwarding unit
	modport sink (
		input alu, rs2, pc4, csr_rdata,
		input mem_we, mem_req,
		input wb_sel, reg_we, rd
	);

endinterface

//--- source/fwd_unit.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module fwd_unit (
	input  logic [`RV_RADDR_W-1:0] rs1_addr_i,
	input  logic [`RV_RADDR_W-1:0] rs2_addr_i,
	ex_mem_if.sink                 ex_mem,
	input  logic [`RV_RADDR_W-1:0] rd_wb_i,
	input  logic                   reg_we_wb_i,
	output rv_pkg::fwd_sel_e       fwd_a_o,
	output rv_pkg::fwd_sel_e       fwd_b_o
);

	function automatic rv_pkg::fwd_sel_e pick_src(input logic [`RV_RADDR_W-1:0] src);
		logic hit_mem;
		logic hit_wb;
		hit_mem = ex_mem.reg_we && (ex_mem.rd != '0) && (ex_mem.rd == src);
		hit_wb = reg_we_wb_i && (rd_wb_i != '0) && (rd_wb_i == src);
		if (hit_mem) begin
			return rv_pkg::fwd_mem; // youngest result wins
		end else if (hit_wb) begin
			return rv_pkg::fwd_wb;
		end
		return rv_pkg::fwd_reg;
	endfunction

	always_comb begin
		fwd_a_o = pick_src(rs1_addr_i);
		fwd_b_o = pick_src(rs2_addr_i);
	end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module alu (
	input  logic [`RV_XLEN-1:0] a_i,
	input  logic [`RV_XLEN-1:0] b_i,
	input  rv_pkg::alu_op_e     op_i,
	output logic [`RV_XLEN-1:0] result_o
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = b_i[4:0];
	assign lt_s = $signed(a_i) < $signed(b_i);
	assign lt_u = a_i < b_i;

	always_comb begin
		case (op_i)
			rv_pkg::alu_add:    result_o = a_i + b_i;
			rv_pkg::alu_sub:    result_o = a_i - b_i;
			rv_pkg::alu_sll:    result_o = a_i << shamt;
			rv_pkg::alu_slt:    result_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
			rv_pkg::alu_sltu:   result_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
			rv_pkg::alu_xor:    result_o = a_i ^ b_i;
			rv_pkg::alu_srl:    result_o = a_i >> shamt;
			rv_pkg::alu_sra:    result_o = $unsigned($signed(a_i) >>> shamt);
			rv_pkg::alu_or:     result_o = a_i | b_i;
			rv_pkg::alu_and:    result_o = a_i & b_i;
			rv_pkg::alu_pass_b: result_o = b_i; // lui, csr read
			default:            result_o = '0;
		endcase
	end

endmodule

//--- source/br_comp.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module br_comp (
	input  logic [`RV_XLEN-1:0] a_i,
	input  logic [`RV_XLEN-1:0] b_i,
	input  logic                br_un_i,
	output logic                br_eq_o,
	output logic                br_lt_o
);

	logic lt_s;
	logic lt_u;

	assign lt_s = $signed(a_i) < $signed(b_i);
	assign lt_u = a_i < b_i;

	assign br_eq_o = (a_i == b_i);
	assign br_lt_o = br_un_i ? lt_u : lt_s; // bltu/bgeu vs blt/bge

endmodule

//--- source/ex_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module ex_stage (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   enable_i,
	input  logic                   flush_i,
	input  logic [`RV_XLEN-1:0]    rs1_i,
	input  logic [`RV_XLEN-1:0]    rs2_i,
	input  logic [`RV_XLEN-1:0]    imm_i,
	input  logic [`RV_XLEN-1:0]    pc_i,
	input  logic [`RV_XLEN-1:0]    pc4_i,
	input  logic [`RV_XLEN-1:0]    csr_rdata_i,
	input  rv_pkg::ex_ctrl_t       ctrl_i,
	input  rv_pkg::fwd_sel_e       fwd_a_i,
	input  rv_pkg::fwd_sel_e       fwd_b_i,
	input  logic [`RV_XLEN-1:0]    data_wb_i,
	ex_mem_if.stage                ex_mem,
	output logic [`RV_XLEN-1:0]    alu_o,
	output logic                   br_eq_o,
	output logic                   br_lt_o
);

	logic [`RV_XLEN-1:0]    rs1_fwd, rs2_fwd;
	logic [`RV_XLEN-1:0]    op_a, op_b;
	logic [`RV_XLEN-1:0]    alu_q, rs2_q, pc4_q, csr_q;
	logic                   mem_we_q, mem_req_q, reg_we_q;
	rv_pkg::wb_sel_e        wb_sel_q;
	logic [`RV_RADDR_W-1:0] rd_q;

	function automatic logic [`RV_XLEN-1:0] fwd_mux(input rv_pkg::fwd_sel_e sel,
			input logic [`RV_XLEN-1:0] reg_val, input logic [`RV_XLEN-1:0] mem_val,
			input logic [`RV_XLEN-1:0] wb_val);
		case (sel)
			rv_pkg::fwd_mem: return mem_val;
			rv_pkg::fwd_wb:  return wb_val;
			default:         return reg_val;
		endcase
	endfunction

	assign rs1_fwd = fwd_mux(fwd_a_i, rs1_i, alu_q, data_wb_i);
	assign rs2_fwd = fwd_mux(fwd_b_i, rs2_i, alu_q, data_wb_i);

	assign op_a = ctrl_i.a_pc ? pc_i : rs1_fwd;
	// csr read value overrides the immediate and register choice
	assign op_b = ctrl_i.csr_b ? csr_rdata_i : (ctrl_i.b_imm ? imm_i : rs2_fwd);

	alu u_alu (
		.a_i      (op_a),
		.b_i      (op_b),
		.op_i     (ctrl_i.alu_op),
		.result_o (alu_o)
	);

	br_comp u_br_comp (
		.a_i     (rs1_fwd), // compare register values, not pc/imm
		.b_i     (rs2_fwd),
		.br_un_i (ctrl_i.br_un),
		.br_eq_o (br_eq_o),
		.br_lt_o (br_lt_o)
	);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			alu_q     <= `RV_PIPE_RST;
			rs2_q     <= `RV_PIPE_RST;
			pc4_q     <= `RV_PIPE_RST;
			csr_q     <= `RV_PIPE_RST;
			mem_we_q  <= 1'b0;
			mem_req_q <= 1'b0;
			wb_sel_q  <= rv_pkg::wb_alu;
			reg_we_q  <= 1'b0;
			rd_q      <= '0;
		end else if (enable_i) begin
			if (flush_i) begin // bubble
				alu_q     <= `RV_PIPE_RST;
				rs2_q     <= `RV_PIPE_RST;
				pc4_q     <= `RV_PIPE_RST;
				csr_q     <= `RV_PIPE_RST;
				mem_we_q  <= 1'b0;
				mem_req_q <= 1'b0;
				wb_sel_q  <= rv_pkg::wb_alu;
				reg_we_q  <= 1'b0;
				rd_q      <= '0;
			end else begin
				alu_q     <= alu_o;
				rs2_q     <= rs2_fwd; // store data after forwarding
				pc4_q     <= pc4_i;
				csr_q     <= csr_rdata_i;
				mem_we_q  <= ctrl_i.mem_we;
				mem_req_q <= ctrl_i.mem_req;
				wb_sel_q  <= ctrl_i.wb_sel;
				reg_we_q  <= ctrl_i.reg_we;
				rd_q      <= ctrl_i.rd;
			end
		end
	end

	assign ex_mem.alu       = alu_q;
	assign ex_mem.rs2       = rs2_q;
	assign ex_mem.pc4       = pc4_q;
	assign ex_mem.csr_rdata = csr_q;
	assign ex_mem.mem_we    = mem_we_q;
	assign ex_mem.mem_req   = mem_req_q;
	assign ex_mem.wb_sel    = wb_sel_q;
	assign ex_mem.reg_we    = reg_we_q;
	assign ex_mem.rd        = rd_q;

endmodule

//--- source/wb_stage.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module wb_stage (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   enable_i,
	ex_mem_if.sink                 ex_mem,
	input  logic [`RV_XLEN-1:0]    mem_rdata_i,
	output logic [`RV_XLEN-1:0]    data_wb_o,
	output logic [`RV_RADDR_W-1:0] rd_wb_o,
	output logic                   reg_we_wb_o
);

	logic [`RV_XLEN-1:0]    wb_data;
	logic [`RV_XLEN-1:0]    data_q;
	logic [`RV_RADDR_W-1:0] rd_q;
	logic                   reg_we_q;

	always_comb begin
		case (ex_mem.wb_sel)
			rv_pkg::wb_mem: wb_data = mem_rdata_i; // load result
			rv_pkg::wb_pc4: wb_data = ex_mem.pc4;  // jal/jalr link
			rv_pkg::wb_csr: wb_data = ex_mem.csr_rdata;
			default:        wb_data = ex_mem.alu;
		endcase
	end

	// frozen together with EX/MEM on a stall
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			data_q   <= `RV_PIPE_RST;
			rd_q     <= '0;
			reg_we_q <= 1'b0;
		end else if (enable_i) begin
			data_q   <= wb_data;
			rd_q     <= ex_mem.rd;
			reg_we_q <= ex_mem.reg_we;
		end
	end

	assign data_wb_o   = data_q;
	assign rd_wb_o     = rd_q;
	assign reg_we_wb_o = reg_we_q;

endmodule

//--- source/ex_top.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module ex_top (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   enable_i,
	input  logic                   flush_i,
	input  logic [`RV_RADDR_W-1:0] rs1_addr_i,
	input  logic [`RV_RADDR_W-1:0] rs2_addr_i,
	input  logic [`RV_XLEN-1:0]    rs1_i,
	input  logic [`RV_XLEN-1:0]    rs2_i,
	input  logic [`RV_XLEN-1:0]    imm_i,
	input  logic [`RV_XLEN-1:0]    pc_i,
	input  logic [`RV_XLEN-1:0]    pc4_i,
	input  logic [`RV_XLEN-1:0]    csr_rdata_i,
	input  rv_pkg::ex_ctrl_t       ctrl_i,
	input  logic [`RV_XLEN-1:0]    mem_rdata_i,
	output logic [`RV_XLEN-1:0]    alu_o,
	output logic                   br_eq_o,
	output logic                   br_lt_o,
	output logic [`RV_XLEN-1:0]    alu_mem_o,
	output logic [`RV_XLEN-1:0]    rs2_mem_o,
	output logic                   mem_we_o,
	output logic                   mem_req_o,
	output logic [`RV_XLEN-1:0]    data_wb_o,
	output logic [`RV_RADDR_W-1:0] rd_wb_o,
	output logic                   reg_we_wb_o
);

	rv_pkg::fwd_sel_e fwd_a;
	rv_pkg::fwd_sel_e fwd_b;

	ex_mem_if ex_mem ();

	fwd_unit u_fwd (
		.rs1_addr_i  (rs1_addr_i),
		.rs2_addr_i  (rs2_addr_i),
		.ex_mem      (ex_mem.sink),
		.rd_wb_i     (rd_wb_o),
		.reg_we_wb_i (reg_we_wb_o),
		.fwd_a_o     (fwd_a),
		.fwd_b_o     (fwd_b)
	);

	ex_stage u_ex (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.enable_i    (enable_i),
		.flush_i     (flush_i),
		.rs1_i       (rs1_i),
		.rs2_i       (rs2_i),
		.imm_i       (imm_i),
		.pc_i        (pc_i),
		.pc4_i       (pc4_i),
		.csr_rdata_i (csr_rdata_i),
		.ctrl_i      (ctrl_i),
		.fwd_a_i     (fwd_a),
		.fwd_b_i     (fwd_b),
		.data_wb_i   (data_wb_o), // writeback feedback
		.ex_mem      (ex_mem.stage),
		.alu_o       (alu_o),
		.br_eq_o     (br_eq_o),
		.br_lt_o     (br_lt_o)
	);

	wb_stage u_wb (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.enable_i    (enable_i),
		.ex_mem      (ex_mem.sink),
		.mem_rdata_i (mem_rdata_i),
		.data_wb_o   (data_wb_o),
		.rd_wb_o     (rd_wb_o),
		.reg_we_wb_o (reg_we_wb_o)
	);

	// data memory request side
	assign alu_mem_o = ex_mem.alu;
	assign rs2_mem_o = ex_mem.rs2;
	assign mem_we_o  = ex_mem.mem_we;
	assign mem_req_o = ex_mem.mem_req;

endmodule

//--- verif/ex_tb.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module ex_tb;

	localparam int N_ALU = 60;
	localparam int N_BR = 40;
	localparam int N_FWD = 60;
	localparam int N_WB = 40;
	localparam int N_STALL = 60;
	localparam int TIMEOUT = 2 * (6 + N_ALU + N_BR + N_FWD + N_WB + N_STALL);

	logic clk_i, rst_ni, enable_i, flush_i;
	logic [`RV_RADDR_W-1:0] rs1_addr_i, rs2_addr_i, rd_wb_o;
	logic [`RV_XLEN-1:0] rs1_i, rs2_i, imm_i, pc_i, pc4_i, csr_rdata_i, mem_rdata_i;
	rv_pkg::ex_ctrl_t ctrl_i;
	logic [`RV_XLEN-1:0] alu_o, alu_mem_o, rs2_mem_o, data_wb_o;
	logic br_eq_o, br_lt_o, mem_we_o, mem_req_o, reg_we_wb_o;

	// reference copies of EX/MEM (m_) and MEM/WB (w_)
	logic [`RV_XLEN-1:0] m_alu, m_rs2, m_pc4, m_csr, w_data;
	logic m_mem_we, m_mem_req, m_reg_we, w_reg_we;
	logic [1:0] m_wb_sel;
	logic [`RV_RADDR_W-1:0] m_rd, w_rd;
	int errors, checks, tests, cycles, hit_mem_over_wb, hit_wb, hit_x0;

	ex_top dut0 (.*);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] alu_ref(input rv_pkg::alu_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		logic [31:0] r;
		case (op)
			rv_pkg::alu_add:    r = a + b;
			rv_pkg::alu_sub:    r = a - b;
			rv_pkg::alu_sll:    r = a << b[4:0];
			rv_pkg::alu_slt:    r = 32'($signed(a) < $signed(b));
			rv_pkg::alu_sltu:   r = 32'(a < b);
			rv_pkg::alu_xor:    r = a ^ b;
			rv_pkg::alu_srl:    r = a >> b[4:0];
			rv_pkg::alu_sra:    r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
			rv_pkg::alu_or:     r = a | b;
			rv_pkg::alu_and:    r = a & b;
			rv_pkg::alu_pass_b: r = b;
			default:            r = 32'h0;
		endcase
		return r;
	endfunction

	// 0 reg, 1 mem, 2 wb; x0 never hits
	function automatic logic [1:0] fwd_ref(input logic [4:0] src);
		if (m_reg_we && m_rd != 5'd0 && m_rd == src) return 2'd1;
		if (w_reg_we && w_rd != 5'd0 && w_rd == src) return 2'd2;
		return 2'd0;
	endfunction

	function automatic logic [31:0] fwd_value(input logic [1:0] sel, input logic [31:0] reg_val);
		if (sel == 2'd1) return m_alu;
		if (sel == 2'd2) return w_data;
		return reg_val;
	endfunction

	task check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// inputs are already driven; check at the falling edge, then clock once
	task step;
		logic [1:0] sa, sb;
		logic [31:0] a_f, b_f, op_a, op_b, exp_alu, wb_d;
		#40;
		sa = fwd_ref(rs1_addr_i);
		sb = fwd_ref(rs2_addr_i);
		a_f = fwd_value(sa, rs1_i);
		b_f = fwd_value(sb, rs2_i);
		op_a = ctrl_i.a_pc ? pc_i : a_f;
		op_b = ctrl_i.csr_b ? csr_rdata_i : (ctrl_i.b_imm ? imm_i : b_f);
		exp_alu = alu_ref(ctrl_i.alu_op, op_a, op_b);
		if ((sa == 2'd1 && w_reg_we && w_rd == rs1_addr_i) ||
				(sb == 2'd1 && w_reg_we && w_rd == rs2_addr_i)) hit_mem_over_wb++;
		if (sa == 2'd2 || sb == 2'd2) hit_wb++;
		if ((rs1_addr_i == 5'd0 || rs2_addr_i == 5'd0) && m_reg_we && m_rd == 5'd0) hit_x0++;
		check("alu_o", alu_o, exp_alu);
		check("br_eq_o", 32'(br_eq_o), 32'(a_f == b_f));
		check("br_lt_o", 32'(br_lt_o),
			32'(ctrl_i.br_un ? (a_f < b_f) : ($signed(a_f) < $signed(b_f))));
		check("alu_mem_o", alu_mem_o, m_alu);
		check("rs2_mem_o", rs2_mem_o, m_rs2);
		check("mem_we_o", 32'(mem_we_o), 32'(m_mem_we));
		check("mem_req_o", 32'(mem_req_o), 32'(m_mem_req));
		check("data_wb_o", data_wb_o, w_data);
		check("rd_wb_o", 32'(rd_wb_o), 32'(w_rd));
		check("reg_we_wb_o", 32'(reg_we_wb_o), 32'(w_reg_we));
		case (m_wb_sel)
			2'd1:    wb_d = mem_rdata_i;
			2'd2:    wb_d = m_pc4;
			2'd3:    wb_d = m_csr;
			default: wb_d = m_alu;
		endcase
		@(posedge clk_i);
		if (enable_i) begin // stall holds both registers
			w_data = wb_d;
			w_rd = m_rd;
			w_reg_we = m_reg_we;
			m_alu = flush_i ? 32'h0 : exp_alu;
			m_rs2 = flush_i ? 32'h0 : b_f;
			m_pc4 = flush_i ? 32'h0 : pc4_i;
			m_csr = flush_i ? 32'h0 : csr_rdata_i;
			m_mem_we = flush_i ? 1'b0 : ctrl_i.mem_we;
			m_mem_req = flush_i ? 1'b0 : ctrl_i.mem_req;
			m_wb_sel = flush_i ? 2'd0 : 2'(ctrl_i.wb_sel);
			m_reg_we = flush_i ? 1'b0 : ctrl_i.reg_we;
			m_rd = flush_i ? 5'd0 : ctrl_i.rd;
		end
		#10;
	endtask

	task drive_random;
		enable_i = 1'b1;
		flush_i = 1'b0;
		rs1_addr_i = 5'($urandom);
		rs2_addr_i = 5'($urandom);
		rs1_i = $urandom;
		rs2_i = $urandom;
		imm_i = $urandom;
		pc_i = $urandom;
		pc4_i = pc_i + 32'd4;
		csr_rdata_i = $urandom;
		mem_rdata_i = $urandom;
		ctrl_i.alu_op = rv_pkg::alu_op_e'(4'($urandom_range(10)));
		ctrl_i.a_pc = 1'($urandom);
		ctrl_i.b_imm = 1'($urandom);
		ctrl_i.csr_b = ($urandom_range(3) == 0);
		ctrl_i.br_un = 1'($urandom);
		ctrl_i.mem_we = 1'($urandom);
		ctrl_i.mem_req = 1'($urandom);
		ctrl_i.wb_sel = rv_pkg::wb_sel_e'(2'($urandom));
		ctrl_i.reg_we = 1'($urandom);
		ctrl_i.rd = 5'($urandom);
	endtask

	task report(input string name, input int err0);
		tests++;
		$display("test %-7s done, %0d errors", name, errors - err0);
	endtask

	initial begin
		int err0;
		void'($urandom(32'h17e96c17));
		{errors, checks, tests, cycles} = '0;
		{rst_ni, enable_i, flush_i, rs1_addr_i, rs2_addr_i} = '0;
		{rs1_i, rs2_i, imm_i, pc_i, pc4_i, csr_rdata_i, mem_rdata_i} = '0;
		ctrl_i = '0;
		{m_alu, m_rs2, m_pc4, m_csr, w_data} = '0;
		{m_mem_we, m_mem_req, m_reg_we, w_reg_we, m_wb_sel, m_rd, w_rd} = '0;
		repeat (5) @(posedge clk_i);
		#10 rst_ni = 1'b1;

		err0 = errors;
		step(); // all registers still at reset value
		report("reset", err0);

		err0 = errors;
		repeat (N_ALU) begin
			drive_random();
			ctrl_i.rd = '0;
			step();
		end
		report("alu", err0);

		err0 = errors;
		repeat (N_BR) begin
			drive_random();
			ctrl_i.rd = '0;
			case ($urandom_range(2))
				0: rs2_i = rs1_i;
				1: rs2_i = {~rs1_i[31], rs1_i[30:0]}; // opposite signs
				default: ;
			endcase
			step();
		end
		report("branch", err0);

		err0 = errors;
		{hit_mem_over_wb, hit_wb, hit_x0} = '0;
		repeat (N_FWD) begin
			drive_random();
			rs1_addr_i = 5'($urandom_range(3)); // few registers, many hazards
			rs2_addr_i = 5'($urandom_range(3));
			ctrl_i.rd = 5'($urandom_range(3));
			ctrl_i.reg_we = ($urandom_range(3) != 0);
			step();
		end
		if (hit_mem_over_wb == 0 || hit_wb == 0 || hit_x0 == 0) begin
			errors++;
			$display("forwarding test missed a case: mem over wb %0d, wb %0d, x0 %0d",
				hit_mem_over_wb, hit_wb, hit_x0);
		end
		report("forward", err0);

		err0 = errors;
		repeat (N_WB) begin
			drive_random();
			step();
		end
		report("wb", err0);

		err0 = errors;
		repeat (N_STALL) begin
			drive_random();
			enable_i = ($urandom_range(3) != 0);
			flush_i = ($urandom_range(4) == 0);
			step();
		end
		report("stall", err0);

		$display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+source
source/rv_pkg.sv
source/ex_mem_if.sv
source/fwd_unit.sv
source/alu.sv
source/br_comp.sv
source/ex_stage.sv
source/wb_stage.sv
source/ex_top.sv
verif/ex_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 -f list.f --top-module ex_tb -o ex_sim > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/ex_sim > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
